/* hw/spm_rb_pkg.sv */
package spm_rb_pkg;

    //////////////////////////////
    // Widths and basic types
    //////////////////////////////
    localparam int WORD_W     = 32;
    localparam int CFG_ADDR_W = 8;

    typedef logic [WORD_W-1:0]     word_t;     // Monitor / readback data
    typedef logic [WORD_W-1:0]     rb_addr_t;  // Host readback address
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t; // Setpoint write address

    // Config write addresses
    localparam cfg_addr_t CFG_BIAS_U0  = 8'd1;
    localparam cfg_addr_t CFG_Z_SLOPE  = 8'd2;
    localparam cfg_addr_t CFG_SRCS_SEL = 8'd3;
    localparam cfg_addr_t CFG_IN_SEL   = 8'd4;
    localparam cfg_addr_t CFG_Z_CLEAR  = 8'd5;   // Pulse only, no storage

    // Readback map
    localparam rb_addr_t RB_Z            = 32'd100001;
    localparam rb_addr_t RB_BIAS         = 32'd100002;
    localparam rb_addr_t RB_GVP_BIAS     = 32'd100003;
    localparam rb_addr_t RB_SRCS_MUX     = 32'd100010;
    localparam rb_addr_t RB_IN_MUX       = 32'd100011;
    localparam rb_addr_t RB_TIMING_TEST  = 32'd101999;
    localparam rb_addr_t RB_TIMING_CLEAR = 32'd102000;
    localparam rb_addr_t RB_VERSION      = 32'd199997;
    localparam rb_addr_t RB_SYSTEM_STATE = 32'd199999;

    // Fixed values
    localparam word_t VERSION_A         = 32'hEC01_0099;
    localparam word_t VERSION_B         = 32'h0001_0300;
    localparam word_t TIMING_TEST_VALUE = 32'd125000000; // One second of aclk
    localparam word_t HEARTBEAT_OFFSET  = 32'd13;

    // Signed clamp limits
    localparam word_t                WORD_MAX = 32'h7FFF_FFFF;
    localparam word_t                WORD_MIN = 32'h8000_0000;
    localparam logic signed [33:0]   WIDE_MAX = 34'sh0_7FFF_FFFF;
    localparam logic signed [33:0]   WIDE_MIN = 34'sh3_8000_0000;

    //////////////////////////////
    // Structs
    //////////////////////////////
    typedef struct packed {
        word_t bias_u0;   // Bias set value
        word_t z_slope;   // Signed Z step per tick
        word_t srcs_sel;  // Source mux
        word_t in_sel;    // Input mux
    } cfg_t;

    typedef struct packed {
        word_t sum;
        word_t u0;
        word_t gvp;
        word_t mod;
    } bias_mon_t;

    typedef struct packed {
        word_t pos;
        word_t slope;
    } z_mon_t;

    // Clamp a widened signed sum back to 32 bits
    function automatic word_t sat_word(input logic signed [33:0] value);
        if (value > WIDE_MAX)
            return WORD_MAX;
        else if (value < WIDE_MIN)
            return WORD_MIN;
        else
            return word_t'(value[31:0]);
    endfunction

endpackage

/* hw/spm_config_regs.sv */
`timescale 1ns/100ps

module spm_config_regs (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  logic                  cfg_wr,
    input  spm_rb_pkg::cfg_addr_t cfg_addr,
    input  spm_rb_pkg::word_t     cfg_data,
    output spm_rb_pkg::cfg_t      cfg,
    output logic                  z_clear
);
    import spm_rb_pkg::*;

    cfg_t cfg_q;     // Setpoint bank
    logic clear_q;   // Z clear pulse

    //////////////////////////////
    // Setpoint register bank
    //////////////////////////////
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cfg_q   <= '0;
            clear_q <= 1'b0;
        end
        else
        begin
            clear_q <= 1'b0;   // Pulse lasts one cycle
            if (cfg_wr)
            begin
                case (cfg_addr)
                    CFG_BIAS_U0:  cfg_q.bias_u0  <= cfg_data;
                    CFG_Z_SLOPE:  cfg_q.z_slope  <= cfg_data;
                    CFG_SRCS_SEL: cfg_q.srcs_sel <= cfg_data;
                    CFG_IN_SEL:   cfg_q.in_sel   <= cfg_data;
                    CFG_Z_CLEAR:
                    begin
                        // Data word is ignored here
                        clear_q <= 1'b1;
                    end
                    default:
                    begin
                        // Unknown address drops the write
                    end
                endcase
            end
        end
    end

    assign cfg     = cfg_q;
    assign z_clear = clear_q;

endmodule

/* hw/spm_bias_sum.sv */
`timescale 1ns/100ps

module spm_bias_sum (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  spm_rb_pkg::cfg_t      cfg,
    input  spm_rb_pkg::word_t     bias_gvp,
    input  spm_rb_pkg::word_t     bias_mod,
    output spm_rb_pkg::bias_mon_t bias_mon
);
    import spm_rb_pkg::*;

    logic signed [33:0] sum_wide;   // Two guard bits
    word_t              sum_sat;
    bias_mon_t          mon_q;

    //////////////////////////////
    // U0 + GVP + Mod
    //////////////////////////////
    always_comb
    begin
        // Sign-extend each term before adding
        sum_wide = $signed({{2{cfg.bias_u0[31]}}, cfg.bias_u0})
                 + $signed({{2{bias_gvp[31]}}, bias_gvp})
                 + $signed({{2{bias_mod[31]}}, bias_mod});
        sum_sat  = sat_word(sum_wide);   // Clamp to signed 32
    end

    // Monitor snapshot, components kept beside the sum
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mon_q <= '0;
        end
        else
        begin
            mon_q.sum <= sum_sat;
            mon_q.u0  <= cfg.bias_u0;   // Set value as used
            mon_q.gvp <= bias_gvp;      // GVP offset
            mon_q.mod <= bias_mod;      // LockIn / aux modulation
        end
    end

    assign bias_mon = mon_q;

endmodule

/* hw/spm_z_ramp.sv */
`timescale 1ns/100ps

module spm_z_ramp (
    input  logic               aclk,
    input  logic               arst_n,
    input  spm_rb_pkg::cfg_t   cfg,
    input  logic               z_tick,
    input  logic               z_clear,
    output spm_rb_pkg::z_mon_t z_mon
);
    import spm_rb_pkg::*;

    logic signed [33:0] pos_next;   // Widened step result
    word_t              pos_q;
    word_t              slope_q;

    // Position plus signed slope, clamped
    always_comb
    begin
        pos_next = $signed({{2{pos_q[31]}}, pos_q})
                 + $signed({{2{cfg.z_slope[31]}}, cfg.z_slope});
    end

    //////////////////////////////
    // Z accumulator
    //////////////////////////////
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pos_q   <= '0;
            slope_q <= '0;
        end
        else
        begin
            slope_q <= cfg.z_slope;         // Slope in use
            if (z_clear)
                pos_q <= '0;                // Clear wins over tick
            else if (z_tick)
                pos_q <= sat_word(pos_next);
        end
    end

    assign z_mon.pos   = pos_q;
    assign z_mon.slope = slope_q;

endmodule

/* hw/spm_readback_mux.sv */
`timescale 1ns/100ps

module spm_readback_mux (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  spm_rb_pkg::rb_addr_t  rb_addr,
    input  spm_rb_pkg::cfg_t      cfg,
    input  spm_rb_pkg::bias_mon_t bias_mon,
    input  spm_rb_pkg::z_mon_t    z_mon,
    output spm_rb_pkg::word_t     rb_data_a,
    output spm_rb_pkg::word_t     rb_data_b
);
    import spm_rb_pkg::*;

    word_t rd_a;          // Readback word A
    word_t rd_b;          // Readback word B
    word_t read_count;    // System state reads after a heartbeat
    logic  pending;       // Heartbeat seen since last count
    logic  startup;       // Cold start, cleared by version read

    //////////////////////////////
    // Address decode and readback
    //////////////////////////////
    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_a       <= '0;
            rd_b       <= '0;
            read_count <= '0;
            pending    <= 1'b0;
            startup    <= 1'b1;   // Set on every reset
        end
        else
        begin
            case (rb_addr)
                RB_Z:
                begin
                    rd_a <= z_mon.pos;
                    rd_b <= z_mon.slope;
                end
                RB_BIAS:
                begin
                    rd_a <= bias_mon.sum;   // Total bias
                    rd_b <= bias_mon.u0;
                end
                RB_GVP_BIAS:
                begin
                    rd_a <= bias_mon.gvp;
                    rd_b <= bias_mon.mod;
                end
                RB_SRCS_MUX:
                begin
                    rd_a <= cfg.srcs_sel;
                    rd_b <= '0;
                end
                RB_IN_MUX:
                begin
                    rd_a <= cfg.in_sel;
                    rd_b <= '0;
                end
                RB_TIMING_CLEAR:
                begin
                    rd_a <= '0;
                    rd_b <= '0;
                end
                RB_TIMING_TEST:
                begin
                    // B trails A by one cycle
                    rd_a <= TIMING_TEST_VALUE;
                    rd_b <= rd_a;
                end
                RB_VERSION:
                begin
                    rd_a    <= VERSION_A;
                    rd_b    <= VERSION_B;
                    startup <= 1'b0;   // Stays low until next reset
                end
                RB_SYSTEM_STATE:
                begin
                    rd_a <= read_count;
                    rd_b <= {31'd0, startup};
                    // Count once per visit after a heartbeat
                    if (pending)
                    begin
                        read_count <= read_count + 32'd1;
                        pending    <= 1'b0;
                    end
                end
                default:
                begin
                    // Heartbeat on unmapped addresses
                    rd_a    <= rd_a + 32'd1;
                    rd_b    <= rd_a + HEARTBEAT_OFFSET;
                    pending <= 1'b1;
                end
            endcase
        end
    end

    assign rb_data_a = rd_a;
    assign rb_data_b = rd_b;

endmodule

/* hw/spm_readback_top.sv */
`timescale 1ns/100ps

module spm_readback_top (
    input  logic                  aclk,
    input  logic                  arst_n,
    input  logic                  cfg_wr,
    input  spm_rb_pkg::cfg_addr_t cfg_addr,
    input  spm_rb_pkg::word_t     cfg_data,
    input  spm_rb_pkg::word_t     bias_gvp,
    input  spm_rb_pkg::word_t     bias_mod,
    input  logic                  z_tick,
    input  spm_rb_pkg::rb_addr_t  rb_addr,
    output spm_rb_pkg::word_t     rb_data_a,
    output spm_rb_pkg::word_t     rb_data_b
);
    import spm_rb_pkg::*;

    cfg_t      cfg;        // Current setpoints
    logic      z_clear;    // One-cycle Z reset
    bias_mon_t bias_mon;
    z_mon_t    z_mon;

    //////////////////////////////
    // Setpoints
    //////////////////////////////
    spm_config_regs u_config_regs (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .cfg_wr   (cfg_wr),
        .cfg_addr (cfg_addr),
        .cfg_data (cfg_data),
        .cfg      (cfg),
        .z_clear  (z_clear)
    );

    //////////////////////////////
    // Live monitors
    //////////////////////////////
    spm_bias_sum u_bias_sum (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .cfg      (cfg),
        .bias_gvp (bias_gvp),
        .bias_mod (bias_mod),
        .bias_mon (bias_mon)
    );

    spm_z_ramp u_z_ramp (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .cfg     (cfg),
        .z_tick  (z_tick),
        .z_clear (z_clear),
        .z_mon   (z_mon)
    );

    // Host readback pair
    spm_readback_mux u_readback_mux (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rb_addr   (rb_addr),
        .cfg       (cfg),
        .bias_mon  (bias_mon),
        .z_mon     (z_mon),
        .rb_data_a (rb_data_a),
        .rb_data_b (rb_data_b)
    );

endmodule

/* tests/tb_spm_readback.sv */
`timescale 1ns/100ps

module tb_spm_readback;
    import spm_rb_pkg::*;

    logic      aclk;
    logic      arst_n;
    logic      cfg_wr;
    cfg_addr_t cfg_addr;
    word_t     cfg_data;
    word_t     bias_gvp;
    word_t     bias_mod;
    logic      z_tick;
    rb_addr_t  rb_addr;
    word_t     rb_data_a;
    word_t     rb_data_b;

    int        cycle_count = 0;   // Rising edges since start
    int        checks_done = 0;
    int        wait_limit  = 100; // Spins allowed in one wait
    integer    seed;
    bias_mon_t bias_got;          // Built from the two bias reads
    bias_mon_t bias_exp;

    spm_readback_top u_dut (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .bias_gvp  (bias_gvp),
        .bias_mod  (bias_mod),
        .z_tick    (z_tick),
        .rb_addr   (rb_addr),
        .rb_data_a (rb_data_a),
        .rb_data_b (rb_data_b)
    );

    // 40 ns period
    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk)
        cycle_count <= cycle_count + 1;

    //////////////////////////////
    // Failure and waiting
    //////////////////////////////
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Stopped at first error");
    endtask

    // N rising edges, returns on a falling edge
    task automatic wait_cycles(input int n);
        int target;
        int spins;
        target = cycle_count + n;
        spins  = 0;
        while (cycle_count < target)
        begin
            @(negedge aclk);
            spins++;
            if (spins > wait_limit)
            begin
                $display("Timeout: clock counter stopped advancing during a wait");
                abort_run();
            end
        end
    endtask

    function automatic int random_idle();
        return 1 + ($unsigned($random(seed)) % 8);   // 1 to 8 cycles
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks_done++;
        if (got !== exp)
        begin
            $display("ERR at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bias(input bias_mon_t got, input bias_mon_t exp);
        checks_done++;
        if (got !== exp)
        begin
            $display("ERR at %0t ns: bias_mon got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_z(input z_mon_t got, input z_mon_t exp);
        checks_done++;
        if (got !== exp)
        begin
            $display("ERR at %0t ns: z_mon got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    // Route one readback pair to the matching compare
    task automatic compare_readback(input rb_addr_t addr, input word_t exp_a, input word_t exp_b);
        case (addr)
            RB_Z:
                check_z({rb_data_a, rb_data_b}, {exp_a, exp_b});   // Pos then slope
            RB_BIAS:
            begin
                bias_got.sum = rb_data_a;
                bias_got.u0  = rb_data_b;
                bias_exp.sum = exp_a;
                bias_exp.u0  = exp_b;
            end
            RB_GVP_BIAS:
            begin
                bias_got.gvp = rb_data_a;
                bias_got.mod = rb_data_b;
                bias_exp.gvp = exp_a;
                bias_exp.mod = exp_b;
                check_bias(bias_got, bias_exp);   // Sum half from the last RB_BIAS read
            end
            default:
            begin
                check_word("rb_data_a", rb_data_a, exp_a);
                check_word("rb_data_b", rb_data_b, exp_b);
            end
        endcase
    endtask

    // Unmapped address, B must track A plus 12 and A must keep climbing
    task automatic heartbeat_check(input rb_addr_t addr);
        word_t first_a;
        rb_addr = addr;
        wait_cycles(4);
        check_word("rb_data_b", rb_data_b, rb_data_a + 32'd12);
        first_a = rb_data_a;
        wait_cycles(random_idle());
        check_word("rb_data_b", rb_data_b, rb_data_a + 32'd12);
        if (rb_data_a <= first_a)
        begin
            $display("ERR at %0t ns: rb_data_a got %h expected above %h",
                     $time, rb_data_a, first_a);
            abort_run();
        end
    endtask

    //////////////////////////////
    // Pattern commands
    //////////////////////////////
    task automatic run_command(input integer fd, input logic [7:0] cmd);
        integer           code;
        logic [8*128-1:0] rest;
        cfg_addr_t        waddr;
        rb_addr_t         addr;
        word_t            val_a;
        word_t            val_b;
        case (cmd)
            "#":
                code = $fgets(rest, fd);   // Comment line
            "W":
            begin
                code = $fscanf(fd, "%d %h", waddr, val_a);
                if (code != 2)
                begin
                    $display("Pattern file has an incomplete W line");
                    abort_run();
                end
                cfg_addr = waddr;
                cfg_data = val_a;
                cfg_wr   = 1'b1;
                wait_cycles(1);   // Single write strobe
                cfg_wr   = 1'b0;
                wait_cycles(4);
            end
            "B":
            begin
                code = $fscanf(fd, "%h %h", val_a, val_b);
                if (code != 2)
                begin
                    $display("Pattern file has an incomplete B line");
                    abort_run();
                end
                bias_gvp = val_a;
                bias_mod = val_b;
                wait_cycles(4);
            end
            "T":
            begin
                z_tick = 1'b1;
                wait_cycles(1);
                z_tick = 1'b0;
                wait_cycles(4);
            end
            "R":
            begin
                code = $fscanf(fd, "%d %h %h", addr, val_a, val_b);
                if (code != 3)
                begin
                    $display("Pattern file has an incomplete R line");
                    abort_run();
                end
                rb_addr = addr;
                wait_cycles(4);
                compare_readback(addr, val_a, val_b);
            end
            "H":
            begin
                code = $fscanf(fd, "%d", addr);
                if (code != 1)
                begin
                    $display("Pattern file has an incomplete H line");
                    abort_run();
                end
                wait_cycles(random_idle());   // Idle gap before the check
                heartbeat_check(addr);
            end
            default:
            begin
                $display("Pattern file holds an unknown command %s", cmd);
                abort_run();
            end
        endcase
    endtask

    // Reset, then replay the pattern file
    initial
    begin
        integer     fd;
        integer     code;
        logic [7:0] cmd;
        logic       done;
        seed     = 8707;
        arst_n   = 1'b0;
        cfg_wr   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        bias_gvp = '0;
        bias_mod = '0;
        z_tick   = 1'b0;
        rb_addr  = RB_TIMING_CLEAR;   // Mapped address, heartbeat stays idle
        wait_cycles(16);
        arst_n = 1'b1;
        wait_cycles(2);

        fd = $fopen("tests/readback_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the pattern file tests/readback_patterns.txt");
            abort_run();
        end
        done = 1'b0;
        while (!done)
        begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1)
                done = 1'b1;   // End of file
            else
                run_command(fd, cmd);
        end
        $fclose(fd);

        if (checks_done == 0)
        begin
            $display("The pattern file produced no checks");
            abort_run();
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* tests/readback_patterns.txt */
# W cfg_addr data | B gvp mod | T | R rb_addr exp_a exp_b | H rb_addr
# addresses in decimal, data words in hex
R 199999 00000000 00000001
W 3 0000000a
W 4 00000005
W 7 deadbeef
R 100010 0000000a 00000000
R 100011 00000005 00000000
W 1 00001000
B 00000200 ffffff00
R 100002 00001100 00001000
R 100003 00000200 ffffff00
W 1 7fffff00
B 00000200 00000100
R 100002 7fffffff 7fffff00
R 100003 00000200 00000100
W 1 80000100
B fffffe00 ffffff00
R 100002 80000000 80000100
R 100003 fffffe00 ffffff00
W 2 00000010
T
T
R 100001 00000020 00000010
W 2 40000000
T
T
R 100001 7fffffff 40000000
W 5 00000000
R 100001 00000000 40000000
R 199997 ec010099 00010300
R 102000 00000000 00000000
R 101999 07735940 07735940
R 199999 00000000 00000000
H 123456
R 199999 00000001 00000000
R 199999 00000001 00000000
H 0
R 199999 00000002 00000000

/* sim.f */
hw/spm_rb_pkg.sv
hw/spm_config_regs.sv
hw/spm_bias_sum.sv
hw/spm_z_ramp.sv
hw/spm_readback_mux.sv
hw/spm_readback_top.sv
tests/tb_spm_readback.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the readback testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_spm_readback -f sim.f &&
./obj_dir/Vtb_spm_readback | tee /dev/stderr | grep -qx "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
